// File: verilog/soc_pkg.sv
package soc_pkg;

  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int strb_width = 4;

  // block ram region, one word per four bytes
  localparam logic [addr_width-1 : 0] bram_base_addr = 32'h0000_0000;
  localparam logic [addr_width-1 : 0] bram_top_addr = 32'h0000_4000;
  localparam int bram_words = 4096;

  localparam logic [addr_width-1 : 0] print_base_addr = 32'h1000_0000;
  localparam logic [addr_width-1 : 0] print_top_addr = 32'h1000_0010;

  localparam logic [addr_width-1 : 0] print_data_off = 32'h0000_0000; // low byte is emitted
  localparam logic [addr_width-1 : 0] print_count_off = 32'h0000_0004; // characters sent so far

  localparam logic [addr_width-1 : 0] clint_base_addr = 32'h0200_0000;
  localparam logic [addr_width-1 : 0] clint_top_addr = 32'h0200_C000;

  localparam logic [addr_width-1 : 0] clint_msip_off = 32'h0000_0000;
  localparam logic [addr_width-1 : 0] clint_mtimecmp_lo_off = 32'h0000_4000;
  localparam logic [addr_width-1 : 0] clint_mtimecmp_hi_off = 32'h0000_4004;
  localparam logic [addr_width-1 : 0] clint_mtime_lo_off = 32'h0000_BFF8;
  localparam logic [addr_width-1 : 0] clint_mtime_hi_off = 32'h0000_BFFC;

  localparam logic [data_width-1 : 0] unmapped_rdata = 32'h0; // what a stray read returns

endpackage

// File: verilog/mem_bus_if.sv
`timescale 1ns/1ns

interface mem_bus_if;

  logic [0 : 0] valid;
  logic [0 : 0] instr; // fetch rather than data access
  logic [soc_pkg::addr_width-1 : 0] addr;
  logic [soc_pkg::data_width-1 : 0] wdata;
  logic [soc_pkg::strb_width-1 : 0] wstrb; // zero means read
  logic [soc_pkg::data_width-1 : 0] rdata;
  logic [0 : 0] ready; // one cycle pulse, ends the transfer

  modport requester (
    output valid,
    output instr,
    output addr,
    output wdata,
    output wstrb,
    input  rdata,
    input  ready
  );

  modport responder (
    input  valid,
    input  instr,
    input  addr,
    input  wdata,
    input  wstrb,
    output rdata,
    output ready
  );

endinterface

// File: verilog/bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter (
  input logic clock,
  input logic rst_n,
  mem_bus_if.responder m0,
  mem_bus_if.responder m1,
  mem_bus_if.requester shared
);

  logic busy;
  logic owner; // 1 when m1 holds the bus
  logic last; // requester served most recently
  logic pick;

  always_comb begin
    if (m0.valid == 1 && m1.valid == 1) begin
      pick = ~last; // both waiting, the other one goes first
    end else begin
      pick = m1.valid;
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 0;
      owner <= 0;
      last <= 1;
    end else if (busy == 0) begin
      if (m0.valid == 1 || m1.valid == 1) begin
        busy <= 1;
        owner <= pick;
      end
    end else if (shared.ready == 1) begin
      busy <= 0;
      last <= owner;
    end
  end

  always_comb begin
    if (owner == 1) begin
      shared.valid = busy & m1.valid;
      shared.instr = m1.instr;
      shared.addr = m1.addr;
      shared.wdata = m1.wdata;
      shared.wstrb = m1.wstrb;
    end else begin
      shared.valid = busy & m0.valid;
      shared.instr = m0.instr;
      shared.addr = m0.addr;
      shared.wdata = m0.wdata;
      shared.wstrb = m0.wstrb;
    end
  end

  always_comb begin
    m0.ready = busy & ~owner & shared.ready;
    m1.ready = busy & owner & shared.ready;
    m0.rdata = owner ? '0 : shared.rdata;
    m1.rdata = owner ? shared.rdata : '0;
  end

  // the granted requester has to keep its request up until the responder answers
  hold_until_ready: assert property (@(posedge clock) disable iff (!rst_n)
    busy |-> shared.valid);

endmodule

// File: verilog/addr_decoder.sv
`timescale 1ns/1ns

module addr_decoder (
  input logic clock,
  input logic rst_n,
  mem_bus_if.responder shared,
  mem_bus_if.requester bram_bus,
  mem_bus_if.requester print_bus,
  mem_bus_if.requester clint_bus
);

  logic [soc_pkg::addr_width-1 : 0] base_addr;
  logic [soc_pkg::addr_width-1 : 0] offset_addr;
  logic unmapped;
  logic unmapped_ready;

  always_comb begin
    bram_bus.valid = 0;
    print_bus.valid = 0;
    clint_bus.valid = 0;
    base_addr = '0;
    unmapped = 0;
    if (shared.addr >= soc_pkg::clint_base_addr && shared.addr < soc_pkg::clint_top_addr) begin
      clint_bus.valid = shared.valid;
      base_addr = soc_pkg::clint_base_addr;
    end else if (shared.addr >= soc_pkg::print_base_addr &&
                 shared.addr < soc_pkg::print_top_addr) begin
      print_bus.valid = shared.valid;
      base_addr = soc_pkg::print_base_addr;
    end else if (shared.addr >= soc_pkg::bram_base_addr &&
                 shared.addr < soc_pkg::bram_top_addr) begin
      bram_bus.valid = shared.valid;
      base_addr = soc_pkg::bram_base_addr;
    end else begin
      unmapped = 1;
    end
    offset_addr = shared.addr - base_addr; // responders see region offsets only

    bram_bus.instr = shared.instr;
    bram_bus.addr = offset_addr;
    bram_bus.wdata = shared.wdata;
    bram_bus.wstrb = shared.wstrb;

    print_bus.instr = shared.instr;
    print_bus.addr = offset_addr;
    print_bus.wdata = shared.wdata;
    print_bus.wstrb = shared.wstrb;

    clint_bus.instr = shared.instr;
    clint_bus.addr = offset_addr;
    clint_bus.wdata = shared.wdata;
    clint_bus.wstrb = shared.wstrb;
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      unmapped_ready <= 0;
    end else begin
      unmapped_ready <= shared.valid & unmapped & ~unmapped_ready; // answer stray accesses here
    end
  end

  always_comb begin
    if (bram_bus.ready == 1) begin
      shared.rdata = bram_bus.rdata;
      shared.ready = 1;
    end else if (print_bus.ready == 1) begin
      shared.rdata = print_bus.rdata;
      shared.ready = 1;
    end else if (clint_bus.ready == 1) begin
      shared.rdata = clint_bus.rdata;
      shared.ready = 1;
    end else if (unmapped_ready == 1) begin
      shared.rdata = soc_pkg::unmapped_rdata;
      shared.ready = 1;
    end else begin
      shared.rdata = '0;
      shared.ready = 0;
    end
  end

  one_responder: assert property (@(posedge clock) disable iff (!rst_n)
    $onehot0({bram_bus.ready, print_bus.ready, clint_bus.ready, unmapped_ready}));

endmodule

// File: verilog/bram.sv
`timescale 1ns/1ns

module bram (
  input logic clock,
  input logic rst_n,
  mem_bus_if.responder bus
);

  logic [soc_pkg::data_width-1 : 0] mem [0 : soc_pkg::bram_words-1];
  logic [$clog2(soc_pkg::bram_words)-1 : 0] word_idx;
  logic access;

  assign word_idx = bus.addr[$clog2(soc_pkg::bram_words)+1 : 2]; // byte offset bits dropped
  assign access = bus.valid & ~bus.ready; // first cycle of each transfer only

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      bus.ready <= 0;
    end else begin
      bus.ready <= access;
    end
  end

  always_ff @(posedge clock) begin
    if (access == 1) begin
      bus.rdata <= mem[word_idx]; // old word even when writing
      for (int i = 0; i < soc_pkg::strb_width; i++) begin
        if (bus.wstrb[i] == 1) begin
          mem[word_idx][i*8 +: 8] <= bus.wdata[i*8 +: 8];
        end
      end
    end
  end

endmodule

// File: verilog/print.sv
`timescale 1ns/1ns

module print (
  input  logic clock,
  input  logic rst_n,
  mem_bus_if.responder bus,
  output logic char_valid,
  output logic [7 : 0] char_data
);

  logic [31 : 0] count;
  logic access;
  logic emit;

  assign access = bus.valid & ~bus.ready;
  assign emit = access & bus.wstrb[0] & (bus.addr == soc_pkg::print_data_off);

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      bus.ready <= 0;
      char_valid <= 0;
      count <= '0;
    end else begin
      bus.ready <= access;
      char_valid <= emit; // one pulse per character
      if (emit == 1) begin
        count <= count + 1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (emit == 1) begin
      char_data <= bus.wdata[7 : 0];
    end
    if (access == 1) begin
      bus.rdata <= (bus.addr == soc_pkg::print_count_off) ? count : '0;
    end
  end

endmodule

// File: verilog/clint.sv
`timescale 1ns/1ns

module clint (
  input  logic clock,
  input  logic rst_n,
  mem_bus_if.responder bus,
  output logic msip,
  output logic mtip,
  output logic [63 : 0] mtime
);

  logic [63 : 0] mtimecmp;
  logic access;
  logic wr_en;

  function automatic logic [31 : 0] merge_word(input logic [31 : 0] old_word,
                                               input logic [31 : 0] new_word,
                                               input logic [3 : 0] strb);
    logic [31 : 0] result;
    result = old_word;
    for (int i = 0; i < soc_pkg::strb_width; i++) begin
      if (strb[i] == 1) begin
        result[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return result;
  endfunction

  assign access = bus.valid & ~bus.ready;
  assign wr_en = access & (|bus.wstrb);

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      bus.ready <= 0;
      msip <= 0;
      mtip <= 0;
      mtime <= '0;
      mtimecmp <= '1; // no timer interrupt until software sets a compare value
    end else begin
      bus.ready <= access;
      mtip <= (mtime >= mtimecmp);
      if (wr_en == 1 && bus.addr == soc_pkg::clint_mtime_lo_off) begin
        mtime <= {mtime[63 : 32], merge_word(mtime[31 : 0], bus.wdata, bus.wstrb)};
      end else if (wr_en == 1 && bus.addr == soc_pkg::clint_mtime_hi_off) begin
        mtime <= {merge_word(mtime[63 : 32], bus.wdata, bus.wstrb), mtime[31 : 0]};
      end else begin
        mtime <= mtime + 1; // a write replaces this cycle's tick
      end
      if (wr_en == 1 && bus.addr == soc_pkg::clint_mtimecmp_lo_off) begin
        mtimecmp[31 : 0] <= merge_word(mtimecmp[31 : 0], bus.wdata, bus.wstrb);
      end
      if (wr_en == 1 && bus.addr == soc_pkg::clint_mtimecmp_hi_off) begin
        mtimecmp[63 : 32] <= merge_word(mtimecmp[63 : 32], bus.wdata, bus.wstrb);
      end
      if (wr_en == 1 && bus.wstrb[0] == 1 && bus.addr == soc_pkg::clint_msip_off) begin
        msip <= bus.wdata[0];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (access == 1) begin
      case (bus.addr)
        soc_pkg::clint_msip_off: bus.rdata <= {31'b0, msip};
        soc_pkg::clint_mtimecmp_lo_off: bus.rdata <= mtimecmp[31 : 0];
        soc_pkg::clint_mtimecmp_hi_off: bus.rdata <= mtimecmp[63 : 32];
        soc_pkg::clint_mtime_lo_off: bus.rdata <= mtime[31 : 0];
        soc_pkg::clint_mtime_hi_off: bus.rdata <= mtime[63 : 32];
        default: bus.rdata <= '0;
      endcase
    end
  end

  mtip_from_compare: assert property (@(posedge clock) disable iff (!rst_n)
    mtip && !$past(wr_en) |-> mtime > mtimecmp); // the count has already moved past the compare

endmodule

// File: verilog/soc_mem.sv
`timescale 1ns/1ns

module soc_mem (
  input  logic clock,
  input  logic rst_n,
  input  logic m0_valid,
  input  logic m0_instr,
  input  logic [31 : 0] m0_addr,
  input  logic [31 : 0] m0_wdata,
  input  logic [3 : 0] m0_wstrb,
  output logic [31 : 0] m0_rdata,
  output logic m0_ready,
  input  logic m1_valid,
  input  logic m1_instr,
  input  logic [31 : 0] m1_addr,
  input  logic [31 : 0] m1_wdata,
  input  logic [3 : 0] m1_wstrb,
  output logic [31 : 0] m1_rdata,
  output logic m1_ready,
  output logic msip,
  output logic mtip,
  output logic [63 : 0] mtime,
  output logic char_valid,
  output logic [7 : 0] char_data
);

  mem_bus_if m0 ();
  mem_bus_if m1 ();
  mem_bus_if shared ();
  mem_bus_if bram_bus ();
  mem_bus_if print_bus ();
  mem_bus_if clint_bus ();

  assign m0.valid = m0_valid;
  assign m0.instr = m0_instr;
  assign m0.addr = m0_addr;
  assign m0.wdata = m0_wdata;
  assign m0.wstrb = m0_wstrb;
  assign m0_rdata = m0.rdata;
  assign m0_ready = m0.ready;

  assign m1.valid = m1_valid;
  assign m1.instr = m1_instr;
  assign m1.addr = m1_addr;
  assign m1.wdata = m1_wdata;
  assign m1.wstrb = m1_wstrb;
  assign m1_rdata = m1.rdata;
  assign m1_ready = m1.ready;

  bus_arbiter arbiter_comp (
    .clock (clock),
    .rst_n (rst_n),
    .m0 (m0.responder),
    .m1 (m1.responder),
    .shared (shared.requester)
  );

  addr_decoder decoder_comp (
    .clock (clock),
    .rst_n (rst_n),
    .shared (shared.responder),
    .bram_bus (bram_bus.requester),
    .print_bus (print_bus.requester),
    .clint_bus (clint_bus.requester)
  );

  bram bram_comp (
    .clock (clock),
    .rst_n (rst_n),
    .bus (bram_bus.responder)
  );

  print print_comp (
    .clock (clock),
    .rst_n (rst_n),
    .bus (print_bus.responder),
    .char_valid (char_valid),
    .char_data (char_data)
  );

  clint clint_comp (
    .clock (clock),
    .rst_n (rst_n),
    .bus (clint_bus.responder),
    .msip (msip),
    .mtip (mtip),
    .mtime (mtime)
  );

endmodule

// File: tb/soc_mem_checker.sv
`timescale 1ns/1ns

module soc_mem_checker (
  input  logic clock,
  input  logic rst_n,
  input  logic m0_valid,
  input  logic [31 : 0] m0_addr,
  input  logic [31 : 0] m0_wdata,
  input  logic [3 : 0] m0_wstrb,
  input  logic [31 : 0] m0_rdata,
  input  logic m0_ready,
  input  logic m1_valid,
  input  logic [31 : 0] m1_addr,
  input  logic [31 : 0] m1_wdata,
  input  logic [3 : 0] m1_wstrb,
  input  logic [31 : 0] m1_rdata,
  input  logic m1_ready,
  input  logic msip,
  input  logic mtip,
  input  logic [63 : 0] mtime,
  input  logic char_valid,
  input  logic [7 : 0] char_data,
  output int data_errors,
  output int protocol_errors,
  output int chars_left
);

  logic [31 : 0] mem_model [0 : soc_pkg::bram_words-1];
  logic [3 : 0] known [0 : soc_pkg::bram_words-1]; // bytes written since reset
  logic [7 : 0] char_queue [$];
  logic [31 : 0] char_count;
  logic [63 : 0] mt_exp, mt_last, cmp_exp, cmp_last;
  logic msip_exp;
  int waited [0 : 1];

  function automatic logic [31 : 0] apply_strobes(input logic [31 : 0] old_word,
                                                  input logic [31 : 0] new_word,
                                                  input logic [3 : 0] strb);
    logic [31 : 0] w;
    w = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b] == 1) w[b*8 +: 8] = new_word[b*8 +: 8];
    end
    return w;
  endfunction

  // reads see the state from before the access edge, which is one edge before ready
  task automatic complete(input int port, input logic [31 : 0] addr, input logic [31 : 0] wdata,
                          input logic [3 : 0] wstrb, input logic [31 : 0] rdata);
    logic [31 : 0] expected;
    logic [31 : 0] mask;
    logic [31 : 0] off;
    logic check;
    int idx;
    expected = '0;
    mask = '1;
    check = (wstrb == 0);
    if (addr >= soc_pkg::clint_base_addr && addr < soc_pkg::clint_top_addr) begin
      off = addr - soc_pkg::clint_base_addr;
      if (off == soc_pkg::clint_msip_off) begin
        expected = {31'b0, msip_exp};
        if (wstrb[0] == 1) msip_exp = wdata[0];
      end else if (off == soc_pkg::clint_mtimecmp_lo_off) begin
        expected = cmp_last[31 : 0];
        cmp_exp[31 : 0] = apply_strobes(cmp_last[31 : 0], wdata, wstrb);
      end else if (off == soc_pkg::clint_mtimecmp_hi_off) begin
        expected = cmp_last[63 : 32];
        cmp_exp[63 : 32] = apply_strobes(cmp_last[63 : 32], wdata, wstrb);
      end else if (off == soc_pkg::clint_mtime_lo_off) begin
        expected = mt_last[31 : 0];
        if (wstrb != 0) mt_exp = {mt_last[63 : 32], apply_strobes(mt_last[31 : 0], wdata, wstrb)};
      end else if (off == soc_pkg::clint_mtime_hi_off) begin
        expected = mt_last[63 : 32];
        if (wstrb != 0) mt_exp = {apply_strobes(mt_last[63 : 32], wdata, wstrb), mt_last[31 : 0]};
      end
    end else if (addr >= soc_pkg::print_base_addr && addr < soc_pkg::print_top_addr) begin
      off = addr - soc_pkg::print_base_addr;
      expected = (off == soc_pkg::print_count_off) ? char_count : '0;
      if (off == soc_pkg::print_data_off && wstrb[0] == 1) begin
        char_queue.push_back(wdata[7 : 0]);
        char_count++;
      end
    end else if (addr < soc_pkg::bram_top_addr) begin
      idx = addr[13 : 2];
      expected = mem_model[idx];
      for (int b = 0; b < 4; b++) mask[b*8 +: 8] = {8{known[idx][b]}};
      mem_model[idx] = apply_strobes(mem_model[idx], wdata, wstrb);
      known[idx] = known[idx] | wstrb;
    end else begin
      check = 1; // holes in the map answer zero on writes as well
    end
    if (check == 1 && ((rdata ^ expected) & mask) != 0) begin
      $display("error %0t: m%0d addr %h rdata %h, expected %h", $time, port, addr, rdata, expected);
      data_errors++;
    end
  endtask

  initial begin
    data_errors = 0;
    protocol_errors = 0;
    chars_left = 0;
  end

  always @(posedge clock) begin
    if (!rst_n) begin
      for (int i = 0; i < soc_pkg::bram_words; i++) known[i] = '0;
      char_queue.delete();
      char_count = '0;
      mt_exp = '0;
      mt_last = '0;
      cmp_exp = '1;
      cmp_last = '1;
      msip_exp = 0;
      waited = '{0, 0};
    end else begin
      if (m0_ready == 1 && m0_valid == 0) begin
        $display("error %0t: ready reached m0 while its valid was low", $time);
        protocol_errors++;
      end
      if (m1_ready == 1 && m1_valid == 0) begin
        $display("error %0t: ready reached m1 while its valid was low", $time);
        protocol_errors++;
      end
      if (m0_ready == 1) complete(0, m0_addr, m0_wdata, m0_wstrb, m0_rdata);
      if (m1_ready == 1) complete(1, m1_addr, m1_wdata, m1_wstrb, m1_rdata);
      if (m1_ready == 1 && m0_valid == 1 && m0_ready == 0) waited[0]++;
      if (m0_ready == 1 && m1_valid == 1 && m1_ready == 0) waited[1]++;
      if (m0_ready == 1) waited[0] = 0;
      if (m1_ready == 1) waited[1] = 0;
      for (int p = 0; p < 2; p++) begin
        if (waited[p] > 1) begin
          $display("error %0t: m%0d waited behind %0d transfers", $time, p, waited[p]);
          protocol_errors++;
          waited[p] = 0;
        end
      end
      if (char_valid == 1) begin
        if (char_queue.size() == 0) begin
          $display("error %0t: char_valid %h without a matching write", $time, char_data);
          data_errors++;
        end else if (char_data != char_queue.pop_front()) begin
          $display("error %0t: char_data %h out of order", $time, char_data);
          data_errors++;
        end
      end
      if (mtime != mt_exp || msip != msip_exp || mtip != (mt_last >= cmp_last)) begin
        $display("error %0t: mtime %h msip %b mtip %b, expected %h %b %b", $time, mtime, msip,
                 mtip, mt_exp, msip_exp, mt_last >= cmp_last);
        data_errors++;
      end
      mt_last = mt_exp;
      mt_exp = mt_exp + 1; // the timer ticks on every clock
      cmp_last = cmp_exp;
    end
    chars_left = char_queue.size();
  end

endmodule

// File: tb/tb_soc_mem.sv
`timescale 1ns/1ns

module tb_soc_mem;

  localparam int per_port = 300;
  localparam int total_trans = 2 * per_port;
  localparam int cycle_limit = 40 * total_trans + 200;

  logic clock;
  logic rst_n;
  logic m0_valid, m0_instr, m1_valid, m1_instr;
  logic [31 : 0] m0_addr, m0_wdata, m1_addr, m1_wdata;
  logic [3 : 0] m0_wstrb, m1_wstrb;
  logic [31 : 0] m0_rdata, m1_rdata;
  logic m0_ready, m1_ready;
  logic msip, mtip, char_valid;
  logic [63 : 0] mtime;
  logic [7 : 0] char_data;
  int seed0, seed1;
  int cycles;
  int data_errors, protocol_errors, chars_left;

  soc_mem dut_i (.*);

  soc_mem_checker chk_i (.*);

  initial begin
    clock = 0;
    forever #5 clock = ~clock;
  end

  function automatic logic [31 : 0] next_rand(input int port);
    if (port == 0) begin
      return $random(seed0);
    end
    return $random(seed1);
  endfunction

  // weighted mix over a small bram window, print, clint and holes in the map
  function automatic logic [31 : 0] pick_addr(input logic [31 : 0] r);
    logic [31 : 0] clint_off [0 : 7];
    clint_off = '{soc_pkg::clint_msip_off, soc_pkg::clint_mtimecmp_lo_off,
                  soc_pkg::clint_mtimecmp_hi_off, soc_pkg::clint_mtime_lo_off,
                  soc_pkg::clint_mtime_hi_off, soc_pkg::clint_mtimecmp_lo_off,
                  soc_pkg::clint_msip_off, 32'h0000_0010};
    if (r[3 : 0] < 7) begin
      return soc_pkg::bram_base_addr + {r[9 : 4], 2'b00};
    end else if (r[3 : 0] < 10) begin
      return soc_pkg::print_base_addr + {r[5 : 4], 2'b00};
    end else if (r[3 : 0] < 14) begin
      return soc_pkg::clint_base_addr + clint_off[r[6 : 4]];
    end else if (r[4] == 1) begin
      return soc_pkg::bram_top_addr + {r[11 : 5], 2'b00};
    end
    return 32'h3000_0000 + {r[11 : 5], 2'b00};
  endfunction

  task automatic run_port(input int port, input int count);
    logic [31 : 0] r;
    logic [31 : 0] addr;
    logic [31 : 0] data;
    logic [3 : 0] strb;
    int gap;
    @(posedge clock);
    for (int n = 0; n < count; n++) begin
      r = next_rand(port);
      addr = pick_addr(r);
      data = next_rand(port);
      if (addr >= soc_pkg::clint_base_addr && addr < soc_pkg::clint_top_addr) begin
        data = data & 32'h0000_0fff; // keeps mtime and mtimecmp close together
      end
      strb = (r[20] == 1 && port == 1) ? r[24 : 21] : 4'h0; // the fetch port only reads
      if (r[20] == 1 && port == 1 && strb == 0) begin
        strb = 4'hf;
      end
      gap = r[27 : 26] == 0 ? r[29 : 28] : 0;
      if (gap > 0) begin
        if (port == 0) m0_valid <= 0;
        else m1_valid <= 0;
        repeat (gap) @(posedge clock);
      end
      if (port == 0) begin
        m0_valid <= 1;
        m0_addr <= addr;
        m0_wdata <= data;
        m0_wstrb <= strb;
      end else begin
        m1_valid <= 1;
        m1_addr <= addr;
        m1_wdata <= data;
        m1_wstrb <= strb;
      end
      forever begin
        @(posedge clock);
        if ((port == 0 && m0_ready == 1) || (port == 1 && m1_ready == 1)) break;
      end
    end
    if (port == 0) m0_valid <= 0;
    else m1_valid <= 0;
  endtask

  task automatic report_counts;
    $display("errors: data %0d, protocol %0d, undelivered characters %0d",
             data_errors, protocol_errors, chars_left);
  endtask

  initial begin
    seed0 = 32'h8ff887a0;
    seed1 = seed0 + 1;
    rst_n = 0;
    m0_valid = 0;
    m0_instr = 1;
    m0_addr = '0;
    m0_wdata = '0;
    m0_wstrb = '0;
    m1_valid = 0;
    m1_instr = 0;
    m1_addr = '0;
    m1_wdata = '0;
    m1_wstrb = '0;
    repeat (4) @(posedge clock);
    rst_n <= 1;
    fork
      run_port(0, per_port);
      run_port(1, per_port);
    join
    repeat (5) @(posedge clock);
    report_counts();
    if (data_errors == 0 && protocol_errors == 0 && chars_left == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clock);
      cycles++;
    end
    $display("timeout after %0d cycles, the transactions did not all complete", cycles);
    if (m0_valid == 1) $display("requester m0 is still waiting for ready at %0t", $time);
    if (m1_valid == 1) $display("requester m1 is still waiting for ready at %0t", $time);
    report_counts();
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: soc_mem.f
verilog/soc_pkg.sv
verilog/mem_bus_if.sv
verilog/bus_arbiter.sv
verilog/addr_decoder.sv
verilog/bram.sv
verilog/print.sv
verilog/clint.sv
verilog/soc_mem.sv
tb/soc_mem_checker.sv
tb/tb_soc_mem.sv

// File: Bender.yml
package:
  name: soc_mem

sources:
  - verilog/soc_pkg.sv
  - verilog/mem_bus_if.sv
  - verilog/bus_arbiter.sv
  - verilog/addr_decoder.sv
  - verilog/bram.sv
  - verilog/print.sv
  - verilog/clint.sv
  - verilog/soc_mem.sv
  - target: simulation
    files:
      - tb/soc_mem_checker.sv
      - tb/tb_soc_mem.sv
